// File: src/dma_pkg.sv
package dma_pkg;

   // Datapath widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int LEN_W  = 16;

   // Burst and boundary limits
   localparam int MAX_BEATS  = 16;
   localparam int BEAT_BYTES = 4;
   localparam int PAGE_BYTES = 4096;
   localparam int BEATS_W    = $clog2(MAX_BEATS + 1);
   localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);
   localparam int PAGE_OFS_W = $clog2(PAGE_BYTES);

   // Fixed AR channel fields
   localparam int AXI_LEN_W   = 8;
   localparam int AXI_ID_W    = 1;
   localparam int AXI_SIZE_W  = 3;
   localparam int AXI_BURST_W = 2;
   localparam logic [AXI_SIZE_W-1:0]  AR_SIZE_4B    = 3'd2;
   localparam logic [AXI_BURST_W-1:0] AR_BURST_INCR = 2'b01;
   localparam logic [AXI_ID_W-1:0]    AR_ID         = '0;

   // Engine FSM encoding
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_PLAN = 2'd1;
   localparam logic [1:0] ST_ADDR = 2'd2;
   localparam logic [1:0] ST_DATA = 2'd3;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
   } dma_cfg_t;

   typedef struct packed {
      logic [ADDR_W-1:0]    addr;
      logic [AXI_LEN_W-1:0] len;
   } axi_ar_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } axi_r_t;

   // last marks the final word of the whole transfer
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } axis_t;

endpackage

// File: src/dma_burst_planner.sv
`timescale 1ns/1ns

module dma_burst_planner (
   input  logic [dma_pkg::ADDR_W-1:0]  addr_i,
   input  logic [dma_pkg::LEN_W-1:0]   remaining_i,
   output logic [dma_pkg::BEATS_W-1:0] beats_o
);

   import dma_pkg::*;

   // Bytes until the next page boundary, 1 to PAGE_BYTES
   logic [PAGE_OFS_W:0]   page_bytes_left;
   logic [PAGE_OFS_W:0]   page_size;
   logic [LEN_W-1:0]      page_words;
   logic [LEN_W-1:0]      burst_cap;
   logic [LEN_W-1:0]      count;

   assign page_size = PAGE_BYTES[PAGE_OFS_W:0];

   assign page_bytes_left = page_size - {1'b0, addr_i[PAGE_OFS_W-1:0]};

   // Word aligned addresses only, so the shift is exact
   assign page_words = LEN_W'(page_bytes_left >> BEAT_SHIFT);

   assign burst_cap = LEN_W'(MAX_BEATS);

   // Smallest of remaining words, page room and the burst cap
   always_comb begin
      count = remaining_i;
      if (page_words < count) begin
         count = page_words;
      end
      if (burst_cap < count) begin
         count = burst_cap;
      end
   end

   // count never exceeds MAX_BEATS here
   assign beats_o = count[BEATS_W-1:0];

endmodule

// File: src/dma_read_engine.sv
`timescale 1ns/1ns

module dma_read_engine (
   input  logic                         clk_i,
   input  logic                         rst_n_i,

   input  logic                         start_i,
   input  dma_pkg::dma_cfg_t            cfg_i,

   output logic [dma_pkg::ADDR_W-1:0]   plan_addr_o,
   output logic [dma_pkg::LEN_W-1:0]    plan_remaining_o,
   input  logic [dma_pkg::BEATS_W-1:0]  plan_beats_i,

   output dma_pkg::axi_ar_t             ar_o,
   output logic                         arvalid_o,
   input  logic                         arready_i,

   input  dma_pkg::axi_r_t              r_i,
   input  logic                         rvalid_i,
   output logic                         rready_o,

   output dma_pkg::axis_t               axis_o,
   output logic                         tvalid_o,
   input  logic                         tready_i,

   output logic                         busy_o,
   output logic                         done_o
);

   import dma_pkg::*;

   logic [1:0]          state_q;
   logic [ADDR_W-1:0]   addr_q;
   logic [LEN_W-1:0]    remaining_q;
   logic [BEATS_W-1:0]  beats_q;
   logic                done_q;

   logic                start_ok;
   logic                in_data;
   logic                beat_fire;
   logic                burst_end;
   logic                final_burst;

   // Zero length requests are dropped
   assign start_ok = start_i && (state_q == ST_IDLE) && (cfg_i.len != '0);

   assign in_data     = (state_q == ST_DATA);
   assign beat_fire   = rvalid_i && rready_o;
   assign burst_end   = beat_fire && r_i.last;
   // Remaining count was already reduced when this burst was planned
   assign final_burst = (remaining_q == '0);

   // R and stream move together
   assign rready_o = in_data && tready_i;
   assign tvalid_o = in_data && rvalid_i;

   assign axis_o.data = r_i.data;
   assign axis_o.last = r_i.last && final_burst;

   assign plan_addr_o      = addr_q;
   assign plan_remaining_o = remaining_q;

   assign ar_o.addr = addr_q;
   assign ar_o.len  = AXI_LEN_W'(beats_q - 1'b1);
   assign arvalid_o = (state_q == ST_ADDR);

   assign busy_o = (state_q != ST_IDLE);
   assign done_o = done_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= ST_IDLE;
         addr_q      <= '0;
         remaining_q <= '0;
         beats_q     <= '0;
         done_q      <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (start_ok) begin
                  addr_q      <= cfg_i.addr;
                  remaining_q <= cfg_i.len;
                  state_q     <= ST_PLAN;
               end
            end
            ST_PLAN: begin
               beats_q     <= plan_beats_i;
               remaining_q <= remaining_q - LEN_W'(plan_beats_i);
               state_q     <= ST_ADDR;
            end
            ST_ADDR: begin
               // AR held stable until accepted
               if (arready_i) begin
                  state_q <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (burst_end) begin
                  addr_q <= addr_q + ADDR_W'(beats_q) * ADDR_W'(BEAT_BYTES);
                  if (final_burst) begin
                     done_q  <= 1'b1;
                     state_q <= ST_IDLE;
                  end else begin
                     state_q <= ST_PLAN;
                  end
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

// File: src/dma_read_top.sv
`timescale 1ns/1ns

module dma_read_top (
   input  logic                             clk_i,
   input  logic                             rst_n_i,

   input  logic                             start_i,
   input  dma_pkg::dma_cfg_t                cfg_i,

   // AXI4 read master
   output logic [dma_pkg::ADDR_W-1:0]       araddr_o,
   output logic [dma_pkg::AXI_LEN_W-1:0]    arlen_o,
   output logic [dma_pkg::AXI_SIZE_W-1:0]   arsize_o,
   output logic [dma_pkg::AXI_BURST_W-1:0]  arburst_o,
   output logic [dma_pkg::AXI_ID_W-1:0]     arid_o,
   output logic                             arvalid_o,
   input  logic                             arready_i,
   input  logic [dma_pkg::DATA_W-1:0]       rdata_i,
   input  logic                             rlast_i,
   input  logic                             rvalid_i,
   output logic                             rready_o,

   // Stream output
   output logic [dma_pkg::DATA_W-1:0]       axis_tdata_o,
   output logic                             axis_tlast_o,
   output logic                             axis_tvalid_o,
   input  logic                             axis_tready_i,

   output logic                             busy_o,
   output logic                             done_o
);

   import dma_pkg::*;

   logic [ADDR_W-1:0]   plan_addr;
   logic [LEN_W-1:0]    plan_remaining;
   logic [BEATS_W-1:0]  plan_beats;
   axi_ar_t             ar;
   axi_r_t              r;
   axis_t               axis;

   // Single ID, 4 byte INCR bursts only
   assign arid_o    = AR_ID;
   assign arsize_o  = AR_SIZE_4B;
   assign arburst_o = AR_BURST_INCR;

   assign araddr_o = ar.addr;
   assign arlen_o  = ar.len;

   assign r.data = rdata_i;
   assign r.last = rlast_i;

   assign axis_tdata_o = axis.data;
   assign axis_tlast_o = axis.last;

   dma_burst_planner u_planner (
      .addr_i      (plan_addr),
      .remaining_i (plan_remaining),
      .beats_o     (plan_beats)
   );

   dma_read_engine u_engine (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .start_i          (start_i),
      .cfg_i            (cfg_i),
      .plan_addr_o      (plan_addr),
      .plan_remaining_o (plan_remaining),
      .plan_beats_i     (plan_beats),
      .ar_o             (ar),
      .arvalid_o        (arvalid_o),
      .arready_i        (arready_i),
      .r_i              (r),
      .rvalid_i         (rvalid_i),
      .rready_o         (rready_o),
      .axis_o           (axis),
      .tvalid_o         (axis_tvalid_o),
      .tready_i         (axis_tready_i),
      .busy_o           (busy_o),
      .done_o           (done_o)
   );

endmodule

// File: tests/dma_checker.sv
`timescale 1ns/1ns

module dma_checker (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic [8*24-1:0]                 test_name_i,
   input  logic                            start_i,
   input  dma_pkg::dma_cfg_t               cfg_i,
   input  logic [dma_pkg::ADDR_W-1:0]      araddr_i,
   input  logic [dma_pkg::AXI_LEN_W-1:0]   arlen_i,
   input  logic [dma_pkg::AXI_SIZE_W-1:0]  arsize_i,
   input  logic [dma_pkg::AXI_BURST_W-1:0] arburst_i,
   input  logic [dma_pkg::AXI_ID_W-1:0]    arid_i,
   input  logic                            arvalid_i,
   input  logic                            arready_i,
   input  logic                            rready_i,
   input  logic [dma_pkg::DATA_W-1:0]      tdata_i,
   input  logic                            tlast_i,
   input  logic                            tvalid_i,
   input  logic                            tready_i,
   input  logic                            busy_i,
   input  logic                            done_i,
   input  logic                            final_i,
   output int                              err_count_o,
   output int                              accept_count_o,
   output int                              done_count_o
);

   import dma_pkg::*;

   int          errors = 0;
   int          accepts = 0;
   int          dones = 0;
   bit          active = 1'b0;
   bit          done_due = 1'b0;
   bit          final_seen = 1'b0;
   logic [31:0] ar_addr_exp = '0;
   int          ar_left = 0;
   logic [31:0] st_addr_exp = '0;
   int          st_left = 0;

   assign err_count_o    = errors;
   assign accept_count_o = accepts;
   assign done_count_o   = dones;

   function automatic logic [31:0] expected_word(input logic [31:0] addr);
      return {addr[15:0], ~addr[31:16]} ^ 32'h3C5A_96E1;
   endfunction

   // Grow the burst a word at a time until a limit stops it
   function automatic int expected_beats(input logic [31:0] addr, input int left);
      int beats;
      beats = 1;
      while (beats < left && beats < 16 &&
             ((addr + 32'(4 * beats)) >> 12) == (addr >> 12)) begin
         beats = beats + 1;
      end
      return beats;
   endfunction

   always @(posedge clk_i) begin
      int exp_beats;
      if (!rst_n_i) begin
         if (arvalid_i || rready_i || tvalid_i || busy_i || done_i) begin
            errors++;
            $display("Outputs are not all low during reset");
         end
      end else begin
         // Done belongs to the cycle after the final beat
         if (done_i) dones++;
         if (done_due && !done_i) begin
            errors++;
            $display("Missing done pulse after the final beat of %0s", test_name_i);
         end
         if (!done_due && done_i) begin
            errors++;
            $display("Done pulse in %0s without a finished transfer", test_name_i);
         end
         if (done_i && busy_i) begin
            errors++;
            $display("Busy still high in the done cycle of %0s", test_name_i);
         end
         done_due = 1'b0;
         if (!active && busy_i) begin
            errors++;
            $display("Busy high in %0s with no transfer open", test_name_i);
         end
         if (active && !busy_i) begin
            errors++;
            $display("Busy low in %0s while a transfer is open", test_name_i);
         end

         if (start_i && !busy_i && cfg_i.len != '0) begin
            active      = 1'b1;
            accepts++;
            ar_addr_exp = cfg_i.addr;
            st_addr_exp = cfg_i.addr;
            ar_left     = int'(cfg_i.len);
            st_left     = int'(cfg_i.len);
         end

         if (arvalid_i && arready_i) begin
            if (!active || ar_left == 0) begin
               errors++;
               $display("AR at %h in %0s with no words left to request", araddr_i, test_name_i);
            end else begin
               exp_beats = expected_beats(ar_addr_exp, ar_left);
               if (araddr_i !== ar_addr_exp) begin
                  errors++;
                  $display("Fail %0s araddr expected %h actual %h",
                           test_name_i, ar_addr_exp, araddr_i);
               end
               if (arlen_i !== 8'(exp_beats - 1)) begin
                  errors++;
                  $display("Fail %0s arlen expected %0d actual %0d",
                           test_name_i, exp_beats - 1, arlen_i);
               end
               if (arsize_i !== 3'd2 || arburst_i !== 2'b01) begin
                  errors++;
                  $display("Fail %0s arsize/arburst expected 2/1 actual %0d/%0d",
                           test_name_i, arsize_i, arburst_i);
               end
               if (arid_i !== 1'b0) begin
                  errors++;
                  $display("Fail %0s arid expected 0 actual %0d", test_name_i, arid_i);
               end
               if (int'(araddr_i[11:0]) + (int'(arlen_i) + 1) * 4 > 4096) begin
                  errors++;
                  $display("Burst at %h crosses a 4 KB boundary", araddr_i);
               end
               ar_addr_exp = ar_addr_exp + 32'(exp_beats * 4);
               ar_left     = ar_left - exp_beats;
            end
         end

         if (tvalid_i && tready_i) begin
            if (!active || st_left == 0) begin
               errors++;
               $display("Extra stream beat %h in %0s with no words left", tdata_i, test_name_i);
            end else begin
               if (tdata_i !== expected_word(st_addr_exp)) begin
                  errors++;
                  $display("Fail %0s tdata expected %h actual %h",
                           test_name_i, expected_word(st_addr_exp), tdata_i);
               end
               if (tlast_i !== (st_left == 1)) begin
                  errors++;
                  $display("Fail %0s tlast expected %0d actual %0d",
                           test_name_i, st_left == 1, tlast_i);
               end
               st_addr_exp = st_addr_exp + 32'd4;
               st_left     = st_left - 1;
               if (st_left == 0) begin
                  active   = 1'b0;
                  done_due = 1'b1;
               end
            end
         end

         if (final_i && !final_seen) begin
            final_seen = 1'b1;
            if (active) begin
               errors++;
               $display("Transfer still open at the end of the run");
            end
            if (accepts != dones) begin
               errors++;
               $display("Done count %0d does not match %0d accepted transfers", dones, accepts);
            end
         end
      end
   end

endmodule

// File: tests/tb_dma_read.sv
`timescale 1ns/1ns

module tb_dma_read;

   import dma_pkg::*;

   localparam int TOTAL_WORDS = 5 + 40 + 24 + 100 + 20;
   localparam int N_TRANSFERS = 5;
   localparam int CYCLE_LIMIT = TOTAL_WORDS * 10 + N_TRANSFERS * 200;

   logic                   clk;
   logic                   rst_n;
   logic                   start;
   dma_cfg_t               cfg;
   logic [ADDR_W-1:0]      araddr;
   logic [AXI_LEN_W-1:0]   arlen;
   logic [AXI_SIZE_W-1:0]  arsize;
   logic [AXI_BURST_W-1:0] arburst;
   logic [AXI_ID_W-1:0]    arid;
   logic                   arvalid;
   logic                   arready;
   logic [DATA_W-1:0]      rdata;
   logic                   rlast;
   logic                   rvalid;
   logic                   rready;
   logic [DATA_W-1:0]      tdata;
   logic                   tlast;
   logic                   tvalid;
   logic                   tready;
   logic                   busy;
   logic                   done;

   logic [8*24-1:0]        test_name;
   logic                   rand_bp;
   logic                   final_check;
   int                     err_count;
   int                     accept_count;
   int                     done_count;
   int                     cycle_count;
   integer                 seed;

   // Slave memory model state
   logic                   r_active;
   logic [31:0]            r_addr;
   int                     r_left;
   int                     ar_wait;

   dma_read_top DUT (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .start_i       (start),
      .cfg_i         (cfg),
      .araddr_o      (araddr),
      .arlen_o       (arlen),
      .arsize_o      (arsize),
      .arburst_o     (arburst),
      .arid_o        (arid),
      .arvalid_o     (arvalid),
      .arready_i     (arready),
      .rdata_i       (rdata),
      .rlast_i       (rlast),
      .rvalid_i      (rvalid),
      .rready_o      (rready),
      .axis_tdata_o  (tdata),
      .axis_tlast_o  (tlast),
      .axis_tvalid_o (tvalid),
      .axis_tready_i (tready),
      .busy_o        (busy),
      .done_o        (done)
   );

   dma_checker u_checker (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .test_name_i    (test_name),
      .start_i        (start),
      .cfg_i          (cfg),
      .araddr_i       (araddr),
      .arlen_i        (arlen),
      .arsize_i       (arsize),
      .arburst_i      (arburst),
      .arid_i         (arid),
      .arvalid_i      (arvalid),
      .arready_i      (arready),
      .rready_i       (rready),
      .tdata_i        (tdata),
      .tlast_i        (tlast),
      .tvalid_i       (tvalid),
      .tready_i       (tready),
      .busy_i         (busy),
      .done_i         (done),
      .final_i        (final_check),
      .err_count_o    (err_count),
      .accept_count_o (accept_count),
      .done_count_o   (done_count)
   );

   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      return {addr[15:0], ~addr[31:16]} ^ 32'h3C5A_96E1;
   endfunction

   task automatic pulse_start(input logic [31:0] addr, input logic [15:0] len);
      start <= 1'b1;
      cfg   <= '{addr: addr, len: len};
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic wait_done();
      do begin
         @(posedge clk);
      end while (!done);
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // AXI slave with random AR delay, random R gaps and stream back-pressure
   initial begin
      seed     = 32'h470dec27;
      arready  = 1'b0;
      rvalid   = 1'b0;
      rdata    = '0;
      rlast    = 1'b0;
      tready   = 1'b0;
      r_active = 1'b0;
      r_addr   = '0;
      r_left   = 0;
      ar_wait  = 0;
      forever begin
         @(posedge clk);
         if (rst_n) begin
            tready <= rand_bp ? (($random(seed) & 3) != 0) : 1'b1;
            if (arvalid && arready) begin
               arready  <= 1'b0;
               r_active <= 1'b1;
               r_addr   <= araddr;
               r_left   <= int'(arlen) + 1;
               ar_wait  <= $random(seed) & 3;
            end else if (arvalid && !r_active && !arready) begin
               if (ar_wait == 0) begin
                  arready <= 1'b1;
               end else begin
                  ar_wait <= ar_wait - 1;
               end
            end
            if (r_active) begin
               if (rvalid && rready) begin
                  if (r_left == 1) begin
                     rvalid   <= 1'b0;
                     rlast    <= 1'b0;
                     r_active <= 1'b0;
                  end else begin
                     r_addr <= r_addr + 32'd4;
                     r_left <= r_left - 1;
                     rvalid <= (($random(seed) & 3) != 0);
                     rdata  <= mem_word(r_addr + 32'd4);
                     rlast  <= (r_left == 2);
                  end
               end else if (!rvalid && (($random(seed) & 3) != 0)) begin
                  rvalid <= 1'b1;
                  rdata  <= mem_word(r_addr);
                  rlast  <= (r_left == 1);
               end
            end
         end
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      $display("Timeout after %0d cycles, the transfers did not complete", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      rst_n       = 1'b1;
      start       = 1'b0;
      cfg         = '0;
      rand_bp     = 1'b0;
      final_check = 1'b0;
      test_name   = "reset";
      #1;
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      test_name <= "t1_short";
      pulse_start(32'h0000_0100, 16'd5);
      wait_done();

      test_name <= "t2_three_bursts";
      pulse_start(32'h0001_0000, 16'd40);
      wait_done();

      // 12 bytes short of the boundary
      test_name <= "t3_page_edge";
      pulse_start(32'h0000_1FF4, 16'd24);
      wait_done();

      test_name <= "t4_backpressure";
      rand_bp   <= 1'b1;
      pulse_start(32'h0000_2F40, 16'd100);
      wait_done();
      rand_bp   <= 1'b0;

      test_name <= "t5_ignored_start";
      pulse_start(32'h0000_5000, 16'd20);
      repeat (4) @(posedge clk);
      pulse_start(32'h0000_6000, 16'd8);
      wait_done();
      repeat (3) @(posedge clk);
      pulse_start(32'h0000_7000, 16'd0);
      repeat (20) @(posedge clk);

      final_check <= 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      $display("Closing: %0d errors, %0d transfers accepted, %0d done pulses",
               err_count, accept_count, done_count);
      if (err_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: sim.f
src/dma_pkg.sv
src/dma_burst_planner.sv
src/dma_read_engine.sv
src/dma_read_top.sv
tests/dma_checker.sv
tests/tb_dma_read.sv

// File: Bender.yml
package:
  name: dma_read

sources:
  # Synthesizable read channel
  - files:
      - src/dma_pkg.sv
      - src/dma_burst_planner.sv
      - src/dma_read_engine.sv
      - src/dma_read_top.sv

  # Simulation only
  - target: test
    files:
      - tests/dma_checker.sv
      - tests/tb_dma_read.sv
